/* hw/harness_pkg.sv */
package harness_pkg;

   // Bus widths
   localparam int addr_width_c = 32;
   localparam int data_width_c = 64;
   localparam int char_width_c = 8;

   // Host I/O region, byte offsets from the base
   localparam logic [addr_width_c-1:0] host_base_c    = 32'h0010_0000;
   localparam logic [addr_width_c-1:0] host_putchar_c = 32'd0;
   localparam logic [addr_width_c-1:0] host_count_c   = 32'd8;
   localparam logic [addr_width_c-1:0] host_finish_c  = 32'd16;

   typedef enum logic {
      mem_rd_e = 1'b0,
      mem_wr_e = 1'b1
   } mem_op_e;

   // 97 bits
   typedef struct packed {
      mem_op_e                  op;
      logic [addr_width_c-1:0]  addr;
      logic [data_width_c-1:0]  data;
   } mem_cmd_s;

   // 65 bits, data is zero for writes
   typedef struct packed {
      mem_op_e                  op;
      logic [data_width_c-1:0]  data;
   } mem_resp_s;

endpackage

/* hw/mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if;

   logic                  cmd_v;
   harness_pkg::mem_cmd_s cmd;
   logic                  cmd_ready;

   logic                   resp_v;
   harness_pkg::mem_resp_s resp;
   logic                   resp_yumi;

   modport requester (
      output cmd_v, cmd, resp_yumi,
      input  cmd_ready, resp_v, resp
   );

   modport memory (
      input  cmd_v, cmd, resp_yumi,
      output cmd_ready, resp_v, resp
   );

endinterface

/* hw/nbf_loader.sv */
`timescale 1ns/1ps

module nbf_loader #(
   parameter int resp_depth_p = 8
) (
   input  logic                                 clk_i,
   input  logic                                 arst_n_i,
   input  logic                                 load_v_i,
   input  logic [harness_pkg::addr_width_c-1:0] load_addr_i,
   input  logic [harness_pkg::data_width_c-1:0] load_data_i,
   input  logic                                 load_last_i,
   output logic                                 load_ready_o,
   output logic                                 load_done_o,
   mem_bus_if.requester                         bus
);

   localparam int cnt_w_lp = $clog2(resp_depth_p + 1);

   logic                  entry_v_r;
   logic                  last_seen_r;
   logic                  done_r;
   harness_pkg::mem_cmd_s cmd_r;
   logic [cnt_w_lp-1:0]   outst_r;
   logic [cnt_w_lp-1:0]   outst_n;
   logic                  load_fire;
   logic                  cmd_fire;

   assign cmd_fire  = bus.cmd_v & bus.cmd_ready;
   // No new entries once the last one is in
   assign load_ready_o = ~last_seen_r & (~entry_v_r | cmd_fire);
   assign load_fire    = load_v_i & load_ready_o;

   assign bus.cmd_v     = entry_v_r;
   assign bus.cmd       = cmd_r;
   assign bus.resp_yumi = bus.resp_v;

   assign outst_n = outst_r + cnt_w_lp'(cmd_fire) - cnt_w_lp'(bus.resp_v);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         entry_v_r   <= 1'b0;
         last_seen_r <= 1'b0;
         outst_r     <= '0;
         done_r      <= 1'b0;
      end else begin
         if (load_fire) begin
            entry_v_r <= 1'b1;
         end else if (cmd_fire) begin
            entry_v_r <= 1'b0;
         end
         last_seen_r <= last_seen_r | (load_fire & load_last_i);
         outst_r     <= outst_n;
         // Last write issued and every write acknowledged
         done_r      <= done_r | (last_seen_r & ~entry_v_r & (outst_n == '0));
      end
   end

   always_ff @(posedge clk_i) begin
      if (load_fire) begin
         cmd_r.op   <= harness_pkg::mem_wr_e;
         cmd_r.addr <= load_addr_i;
         cmd_r.data <= load_data_i;
      end
   end

   assign load_done_o = done_r;

   a_done_sticky : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      load_done_o |=> load_done_o);

endmodule

/* hw/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter #(
   parameter int resp_depth_p = 8
) (
   input  logic         clk_i,
   input  logic         arst_n_i,
   mem_bus_if.memory    ldr_bus,
   mem_bus_if.memory    core_bus,
   mem_bus_if.requester mem_bus
);

   localparam int ptr_w_lp = $clog2(resp_depth_p);
   localparam int cnt_w_lp = $clog2(resp_depth_p + 1);

   logic                prio_core_r;
   logic                grant_ldr;
   logic                grant_core;
   logic                cmd_fire;
   logic                q_full;
   logic                q_empty;
   logic                q_head;
   logic                q_pop;
   logic                q_mem_r [resp_depth_p];
   logic [ptr_w_lp-1:0] wr_ptr_r;
   logic [ptr_w_lp-1:0] rd_ptr_r;
   logic [cnt_w_lp-1:0] q_cnt_r;

   // Round robin, prio_core_r names the favoured requester
   assign grant_ldr  = ldr_bus.cmd_v & (~core_bus.cmd_v | ~prio_core_r);
   assign grant_core = core_bus.cmd_v & (~ldr_bus.cmd_v | prio_core_r);

   assign mem_bus.cmd_v = (ldr_bus.cmd_v | core_bus.cmd_v) & ~q_full;
   assign mem_bus.cmd   = grant_core ? core_bus.cmd : ldr_bus.cmd;
   assign cmd_fire      = mem_bus.cmd_v & mem_bus.cmd_ready;

   assign ldr_bus.cmd_ready  = grant_ldr & mem_bus.cmd_ready & ~q_full;
   assign core_bus.cmd_ready = grant_core & mem_bus.cmd_ready & ~q_full;

   assign q_full  = (q_cnt_r == cnt_w_lp'(resp_depth_p));
   assign q_empty = (q_cnt_r == '0);
   assign q_head  = q_mem_r[rd_ptr_r];

   // Head of the steering queue owns the response at the memory output
   assign ldr_bus.resp_v  = mem_bus.resp_v & ~q_empty & ~q_head;
   assign core_bus.resp_v = mem_bus.resp_v & ~q_empty & q_head;
   assign ldr_bus.resp    = mem_bus.resp;
   assign core_bus.resp   = mem_bus.resp;

   assign mem_bus.resp_yumi = q_head ? core_bus.resp_yumi : ldr_bus.resp_yumi;
   assign q_pop             = mem_bus.resp_yumi;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         prio_core_r <= 1'b0;
         wr_ptr_r    <= '0;
         rd_ptr_r    <= '0;
         q_cnt_r     <= '0;
         for (int i = 0; i < resp_depth_p; i++) begin
            q_mem_r[i] <= 1'b0;
         end
      end else begin
         if (cmd_fire) begin
            prio_core_r       <= grant_ldr;
            q_mem_r[wr_ptr_r] <= grant_core;
            wr_ptr_r <= (wr_ptr_r == ptr_w_lp'(resp_depth_p - 1)) ? '0 : wr_ptr_r + 1'b1;
         end
         if (q_pop) begin
            rd_ptr_r <= (rd_ptr_r == ptr_w_lp'(resp_depth_p - 1)) ? '0 : rd_ptr_r + 1'b1;
         end
         q_cnt_r <= q_cnt_r + cnt_w_lp'(cmd_fire) - cnt_w_lp'(q_pop);
      end
   end

   a_one_grant : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !(ldr_bus.cmd_ready && core_bus.cmd_ready));

   a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      q_pop |-> !q_empty);

endmodule

/* hw/mem_model.sv */
`timescale 1ns/1ps

// dram_latency_p must be at least 2
module mem_model #(
   parameter int mem_words_p    = 256,
   parameter int dram_latency_p = 4,
   parameter int resp_depth_p   = 8
) (
   input  logic      clk_i,
   input  logic      arst_n_i,
   mem_bus_if.memory bus
);

   localparam int idx_w_lp = $clog2(mem_words_p);
   localparam int ptr_w_lp = $clog2(resp_depth_p);
   localparam int cnt_w_lp = $clog2(resp_depth_p + 1);
   localparam int last_lp  = dram_latency_p - 2;

   logic [harness_pkg::data_width_c-1:0] mem_r [mem_words_p];
   logic [idx_w_lp-1:0]    word_idx;
   logic                   cmd_fire;
   logic                   push;
   logic                   pop;
   logic [dram_latency_p-2:0] stage_v_r;
   harness_pkg::mem_resp_s stage_resp_r [dram_latency_p-1];
   harness_pkg::mem_resp_s fifo_r [resp_depth_p];
   logic [ptr_w_lp-1:0]    wr_ptr_r;
   logic [ptr_w_lp-1:0]    rd_ptr_r;
   logic [cnt_w_lp-1:0]    fifo_cnt_r;
   logic [cnt_w_lp-1:0]    used_r;

   // Word index drops the byte offset
   assign word_idx = idx_w_lp'(bus.cmd.addr[harness_pkg::addr_width_c-1:3] % mem_words_p);

   // A credit covers one response from accept until it leaves the FIFO
   assign bus.cmd_ready = (used_r < cnt_w_lp'(resp_depth_p));
   assign cmd_fire      = bus.cmd_v & bus.cmd_ready;

   assign push = stage_v_r[last_lp];
   assign pop  = bus.resp_yumi;

   assign bus.resp_v = (fifo_cnt_r != '0);
   assign bus.resp   = fifo_r[rd_ptr_r];

   always_ff @(posedge clk_i) begin
      if (cmd_fire && bus.cmd.op == harness_pkg::mem_wr_e) begin
         mem_r[word_idx] <= bus.cmd.data;
      end
      stage_resp_r[0].op   <= bus.cmd.op;
      stage_resp_r[0].data <= (bus.cmd.op == harness_pkg::mem_rd_e) ? mem_r[word_idx] : '0;
      for (int i = 1; i <= last_lp; i++) begin
         stage_resp_r[i] <= stage_resp_r[i-1];
      end
      if (push) begin
         fifo_r[wr_ptr_r] <= stage_resp_r[last_lp];
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         stage_v_r  <= '0;
         wr_ptr_r   <= '0;
         rd_ptr_r   <= '0;
         fifo_cnt_r <= '0;
         used_r     <= '0;
      end else begin
         stage_v_r[0] <= cmd_fire;
         for (int i = 1; i <= last_lp; i++) begin
            stage_v_r[i] <= stage_v_r[i-1];
         end
         if (push) begin
            wr_ptr_r <= (wr_ptr_r == ptr_w_lp'(resp_depth_p - 1)) ? '0 : wr_ptr_r + 1'b1;
         end
         if (pop) begin
            rd_ptr_r <= (rd_ptr_r == ptr_w_lp'(resp_depth_p - 1)) ? '0 : rd_ptr_r + 1'b1;
         end
         fifo_cnt_r <= fifo_cnt_r + cnt_w_lp'(push) - cnt_w_lp'(pop);
         used_r     <= used_r + cnt_w_lp'(cmd_fire) - cnt_w_lp'(pop);
      end
   end

   a_fifo_no_overflow : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      push |-> (fifo_cnt_r < cnt_w_lp'(resp_depth_p)) || pop);

endmodule

/* hw/host_device.sv */
`timescale 1ns/1ps

module host_device (
   input  logic                                 clk_i,
   input  logic                                 arst_n_i,
   input  logic                                 io_cmd_v_i,
   input  logic                                 io_cmd_we_i,
   input  logic [harness_pkg::addr_width_c-1:0] io_cmd_addr_i,
   input  logic [harness_pkg::data_width_c-1:0] io_cmd_data_i,
   output logic                                 io_cmd_ready_o,
   output logic                                 io_resp_v_o,
   output logic [harness_pkg::data_width_c-1:0] io_resp_data_o,
   input  logic                                 io_resp_yumi_i,
   output logic                                 putchar_v_o,
   output logic [harness_pkg::char_width_c-1:0] putchar_o,
   output logic                                 finish_o
);

   logic                                 cmd_fire;
   logic                                 hit_putchar;
   logic                                 hit_count;
   logic                                 hit_finish;
   logic                                 resp_v_r;
   logic                                 putchar_v_r;
   logic                                 finish_r;
   logic [harness_pkg::data_width_c-1:0] count_r;
   logic [harness_pkg::data_width_c-1:0] resp_data_r;
   logic [harness_pkg::char_width_c-1:0] char_r;

   assign hit_putchar = (io_cmd_addr_i == harness_pkg::host_base_c + harness_pkg::host_putchar_c);
   assign hit_count   = (io_cmd_addr_i == harness_pkg::host_base_c + harness_pkg::host_count_c);
   assign hit_finish  = (io_cmd_addr_i == harness_pkg::host_base_c + harness_pkg::host_finish_c);

   // One response outstanding at a time
   assign io_cmd_ready_o = ~resp_v_r;
   assign cmd_fire       = io_cmd_v_i & io_cmd_ready_o;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         resp_v_r    <= 1'b0;
         putchar_v_r <= 1'b0;
         finish_r    <= 1'b0;
         count_r     <= '0;
      end else begin
         if (cmd_fire) begin
            resp_v_r <= 1'b1;
         end else if (io_resp_yumi_i) begin
            resp_v_r <= 1'b0;
         end
         putchar_v_r <= cmd_fire & io_cmd_we_i & hit_putchar;
         if (cmd_fire && io_cmd_we_i && hit_putchar) begin
            count_r <= count_r + 1'b1;
         end
         finish_r <= finish_r | (cmd_fire & io_cmd_we_i & hit_finish);
      end
   end

   always_ff @(posedge clk_i) begin
      if (cmd_fire) begin
         resp_data_r <= (!io_cmd_we_i && hit_count) ? count_r : '0;
         char_r      <= io_cmd_data_i[harness_pkg::char_width_c-1:0];
      end
   end

   assign io_resp_v_o    = resp_v_r;
   assign io_resp_data_o = resp_data_r;
   assign putchar_v_o    = putchar_v_r;
   assign putchar_o      = char_r;
   assign finish_o       = finish_r;

   a_finish_sticky : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      finish_o |=> finish_o);

endmodule

/* hw/harness_top.sv */
`timescale 1ns/1ps

module harness_top #(
   parameter int mem_words_p    = 256,
   parameter int dram_latency_p = 4,
   parameter int resp_depth_p   = 8
) (
   input  logic                                 clk_i,
   input  logic                                 arst_n_i,
   // Program load stream
   input  logic                                 load_v_i,
   input  logic [harness_pkg::addr_width_c-1:0] load_addr_i,
   input  logic [harness_pkg::data_width_c-1:0] load_data_i,
   input  logic                                 load_last_i,
   output logic                                 load_ready_o,
   output logic                                 load_done_o,
   // Core memory port
   input  logic                                 core_cmd_v_i,
   input  logic                                 core_cmd_op_i,
   input  logic [harness_pkg::addr_width_c-1:0] core_cmd_addr_i,
   input  logic [harness_pkg::data_width_c-1:0] core_cmd_data_i,
   output logic                                 core_cmd_ready_o,
   output logic                                 core_resp_v_o,
   output logic [harness_pkg::data_width_c-1:0] core_resp_data_o,
   input  logic                                 core_resp_yumi_i,
   // Host I/O
   input  logic                                 io_cmd_v_i,
   input  logic                                 io_cmd_we_i,
   input  logic [harness_pkg::addr_width_c-1:0] io_cmd_addr_i,
   input  logic [harness_pkg::data_width_c-1:0] io_cmd_data_i,
   output logic                                 io_cmd_ready_o,
   output logic                                 io_resp_v_o,
   output logic [harness_pkg::data_width_c-1:0] io_resp_data_o,
   input  logic                                 io_resp_yumi_i,
   output logic                                 putchar_v_o,
   output logic [harness_pkg::char_width_c-1:0] putchar_o,
   output logic                                 finish_o
);

   mem_bus_if ldr_bus ();
   mem_bus_if core_bus ();
   mem_bus_if mem_bus ();

   assign core_bus.cmd_v     = core_cmd_v_i;
   assign core_bus.cmd.op    = harness_pkg::mem_op_e'(core_cmd_op_i);
   assign core_bus.cmd.addr  = core_cmd_addr_i;
   assign core_bus.cmd.data  = core_cmd_data_i;
   assign core_cmd_ready_o   = core_bus.cmd_ready;
   assign core_resp_v_o      = core_bus.resp_v;
   assign core_resp_data_o   = core_bus.resp.data;
   assign core_bus.resp_yumi = core_resp_yumi_i;

   nbf_loader #(
      .resp_depth_p (resp_depth_p)
   ) nbf_loader_inst (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .load_v_i     (load_v_i),
      .load_addr_i  (load_addr_i),
      .load_data_i  (load_data_i),
      .load_last_i  (load_last_i),
      .load_ready_o (load_ready_o),
      .load_done_o  (load_done_o),
      .bus          (ldr_bus.requester)
   );

   mem_arbiter #(
      .resp_depth_p (resp_depth_p)
   ) mem_arbiter_inst (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .ldr_bus  (ldr_bus.memory),
      .core_bus (core_bus.memory),
      .mem_bus  (mem_bus.requester)
   );

   mem_model #(
      .mem_words_p    (mem_words_p),
      .dram_latency_p (dram_latency_p),
      .resp_depth_p   (resp_depth_p)
   ) mem_model_inst (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .bus      (mem_bus.memory)
   );

   host_device host_device_inst (
      .clk_i          (clk_i),
      .arst_n_i       (arst_n_i),
      .io_cmd_v_i     (io_cmd_v_i),
      .io_cmd_we_i    (io_cmd_we_i),
      .io_cmd_addr_i  (io_cmd_addr_i),
      .io_cmd_data_i  (io_cmd_data_i),
      .io_cmd_ready_o (io_cmd_ready_o),
      .io_resp_v_o    (io_resp_v_o),
      .io_resp_data_o (io_resp_data_o),
      .io_resp_yumi_i (io_resp_yumi_i),
      .putchar_v_o    (putchar_v_o),
      .putchar_o      (putchar_o),
      .finish_o       (finish_o)
   );

endmodule

/* testbench/harness_tb.sv */
`timescale 1ns/1ps

module harness_tb;

   localparam int cycles_per_line_c = 50;

   logic clk_i = 1'b0;
   logic arst_n_i;
   logic load_v_i, load_last_i, load_ready_o, load_done_o;
   logic [harness_pkg::addr_width_c-1:0] load_addr_i, core_cmd_addr_i, io_cmd_addr_i;
   logic [harness_pkg::data_width_c-1:0] load_data_i, core_cmd_data_i, io_cmd_data_i;
   logic [harness_pkg::data_width_c-1:0] core_resp_data_o, io_resp_data_o;
   logic core_cmd_v_i, core_cmd_op_i, core_cmd_ready_o, core_resp_v_o, core_resp_yumi_i;
   logic io_cmd_v_i, io_cmd_we_i, io_cmd_ready_o, io_resp_v_o, io_resp_yumi_i;
   logic putchar_v_o, finish_o;
   logic [harness_pkg::char_width_c-1:0] putchar_o;

   // One entry per data line
   logic [7:0]                           op_q [$];
   logic [harness_pkg::addr_width_c-1:0] addr_q [$];
   logic [harness_pkg::data_width_c-1:0] data_q [$];
   logic                                 flag_q [$];

   harness_pkg::mem_resp_s               core_exp_q [$];
   harness_pkg::mem_resp_s               io_exp_q [$];
   logic [harness_pkg::char_width_c-1:0] char_exp_q [$];

   logic [31:0] lfsr_r = 32'd80480;
   int          cycle_cnt = 0;
   int          cycle_limit = 0;
   int          err_cnt = 0;
   logic        done_seen = 1'b0;
   logic        finish_seen = 1'b0;

   harness_top harness_top_inst (.*);

   always #2 clk_i = ~clk_i;

   task automatic report_failure(input string msg);
      err_cnt++;
      $display("%s", msg);
      $display("Errors found");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic check_mem_resp(input harness_pkg::mem_resp_s act,
                                 input harness_pkg::mem_resp_s exp, input string what);
      if (act !== exp) begin
         report_failure($sformatf("Error at time %0t: %s response op %0d data %h, expected op %0d data %h",
                                  $time, what, act.op, act.data, exp.op, exp.data));
      end
   endtask

   task automatic check_char(input logic [harness_pkg::char_width_c-1:0] act,
                             input logic [harness_pkg::char_width_c-1:0] exp);
      if (act !== exp) begin
         report_failure($sformatf("Error at time %0t: putchar %h, expected %h", $time, act, exp));
      end
   endtask

   task automatic check_bit(input logic act, input logic exp, input string what);
      if (act !== exp) begin
         report_failure($sformatf("Error at time %0t: %s is %b, expected %b", $time, what, act, exp));
      end
   endtask

   // Galois form, polynomial x^32 + x^22 + x^2 + x + 1
   function automatic logic next_lfsr_bit();
      logic bit_out;
      bit_out = lfsr_r[0];
      lfsr_r  = {1'b0, lfsr_r[31:1]} ^ (bit_out ? 32'h8020_0003 : 32'h0);
      return bit_out;
   endfunction

   task automatic start_op();
      @(negedge clk_i);
      core_cmd_v_i = 1'b0;
      io_cmd_v_i   = 1'b0;
   endtask

   task automatic core_cmd(input logic we, input logic [harness_pkg::addr_width_c-1:0] addr,
                           input logic [harness_pkg::data_width_c-1:0] data);
      harness_pkg::mem_resp_s exp_resp;
      exp_resp.op   = we ? harness_pkg::mem_wr_e : harness_pkg::mem_rd_e;
      exp_resp.data = we ? '0 : data;
      start_op();
      core_cmd_v_i    = 1'b1;
      core_cmd_op_i   = exp_resp.op;
      core_cmd_addr_i = addr;
      core_cmd_data_i = we ? data : '0;
      #1;
      while (!core_cmd_ready_o) begin
         @(negedge clk_i);
         #1;
      end
      core_exp_q.push_back(exp_resp);
   endtask

   // One I/O command at a time, waits for its response
   task automatic io_cmd(input logic we, input logic [harness_pkg::addr_width_c-1:0] addr,
                         input logic [harness_pkg::data_width_c-1:0] data);
      harness_pkg::mem_resp_s exp_resp;
      exp_resp.op   = we ? harness_pkg::mem_wr_e : harness_pkg::mem_rd_e;
      exp_resp.data = we ? '0 : data;
      start_op();
      io_cmd_v_i    = 1'b1;
      io_cmd_we_i   = we;
      io_cmd_addr_i = addr;
      io_cmd_data_i = we ? data : '0;
      #1;
      while (!io_cmd_ready_o) begin
         @(negedge clk_i);
         #1;
      end
      io_exp_q.push_back(exp_resp);
      @(negedge clk_i);
      io_cmd_v_i = 1'b0;
      while (io_exp_q.size() != 0) begin
         @(negedge clk_i);
         #1;
      end
   endtask

   task automatic wait_core_idle();
      while (core_exp_q.size() != 0) begin
         @(negedge clk_i);
         #1;
      end
   endtask

   task automatic load_stream();
      for (int i = 0; i < op_q.size(); i++) begin
         if (op_q[i] == "L") begin
            @(negedge clk_i);
            load_v_i    = 1'b1;
            load_addr_i = addr_q[i];
            load_data_i = data_q[i];
            load_last_i = flag_q[i];
            #1;
            while (!load_ready_o) begin
               @(negedge clk_i);
               #1;
            end
         end
      end
      @(negedge clk_i);
      load_v_i = 1'b0;
   endtask

   // Random yumi on both response channels, responses checked in order
   always @(negedge clk_i) begin : resp_check
      logic                   core_bit;
      logic                   io_bit;
      harness_pkg::mem_resp_s act;
      harness_pkg::mem_resp_s exp;
      if (arst_n_i) begin
         core_bit         = next_lfsr_bit();
         io_bit           = next_lfsr_bit();
         core_resp_yumi_i = core_resp_v_o & core_bit;
         io_resp_yumi_i   = io_resp_v_o & io_bit;
         if (core_resp_yumi_i) begin
            if (core_exp_q.size() == 0) begin
               report_failure("Core response arrived with no core command outstanding");
            end
            exp      = core_exp_q.pop_front();
            act.op   = exp.op;
            act.data = core_resp_data_o;
            check_mem_resp(act, exp, "core");
         end
         if (io_resp_yumi_i) begin
            if (io_exp_q.size() == 0) begin
               report_failure("I/O response arrived with no I/O command outstanding");
            end
            exp      = io_exp_q.pop_front();
            act.op   = exp.op;
            act.data = io_resp_data_o;
            check_mem_resp(act, exp, "I/O");
         end
      end
   end

   always @(negedge clk_i) begin
      if (done_seen) begin
         check_bit(load_done_o, 1'b1, "load_done_o after rising");
      end
      if (finish_seen) begin
         check_bit(finish_o, 1'b1, "finish_o after rising");
      end
      done_seen   = done_seen | (load_done_o === 1'b1);
      finish_seen = finish_seen | (finish_o === 1'b1);
      if (putchar_v_o === 1'b1) begin
         if (char_exp_q.size() == 0) begin
            report_failure("Console character printed that was not expected");
         end
         check_char(putchar_o, char_exp_q.pop_front());
      end
   end

   always @(posedge clk_i) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
         report_failure($sformatf("Timeout, run not finished after %0d cycles", cycle_limit));
      end
   end

   initial begin : main_seq
      int                                   fd;
      int                                   n;
      string                                line;
      logic [7:0]                           op_c;
      logic [harness_pkg::addr_width_c-1:0] a;
      logic [harness_pkg::data_width_c-1:0] d;
      logic                                 f;
      arst_n_i         = 1'b0;
      load_v_i         = 1'b0;
      load_addr_i      = '0;
      load_data_i      = '0;
      load_last_i      = 1'b0;
      core_cmd_v_i     = 1'b0;
      core_cmd_op_i    = 1'b0;
      core_cmd_addr_i  = '0;
      core_cmd_data_i  = '0;
      core_resp_yumi_i = 1'b0;
      io_cmd_v_i       = 1'b0;
      io_cmd_we_i      = 1'b0;
      io_cmd_addr_i    = '0;
      io_cmd_data_i    = '0;
      io_resp_yumi_i   = 1'b0;
      fd = $fopen("testbench/harness_testdata.txt", "r");
      if (fd == 0) begin
         report_failure("Could not open testbench/harness_testdata.txt");
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() > 1 && line.getc(0) != "#") begin
            n = $sscanf(line, "%c %h %h %h", op_c, a, d, f);
            if (n != 4) begin
               report_failure($sformatf("Malformed data line: %s", line));
            end
            op_q.push_back(op_c);
            addr_q.push_back(a);
            data_q.push_back(d);
            flag_q.push_back(f);
         end
      end
      $fclose(fd);
      cycle_limit = cycles_per_line_c * op_q.size();
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      arst_n_i = 1'b1;
      fork
         load_stream();
      join_none
      for (int i = 0; i < op_q.size(); i++) begin
         case (op_q[i])
            "L": begin
            end
            "W": core_cmd(1'b1, addr_q[i], data_q[i]);
            "R": core_cmd(1'b0, addr_q[i], data_q[i]);
            "P": io_cmd(1'b1, addr_q[i], data_q[i]);
            "Q": io_cmd(1'b0, addr_q[i], data_q[i]);
            "K": char_exp_q.push_back(data_q[i][harness_pkg::char_width_c-1:0]);
            "S": begin
               start_op();
               wait_core_idle();
            end
            "D": begin
               // Timeout catches a load that never completes
               start_op();
               while (load_done_o !== 1'b1) begin
                  @(negedge clk_i);
               end
            end
            "F": begin
               start_op();
               check_bit(finish_o, flag_q[i], "finish_o");
            end
            default: report_failure($sformatf("Unknown operation code on data line %0d", i));
         endcase
      end
      start_op();
      wait_core_idle();
      if (char_exp_q.size() != 0) begin
         report_failure("Some expected console characters were never printed");
      end
      if (err_cnt == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

/* testbench/harness_testdata.txt */
# op addr data flag, all hex. W and P carry write data, R and Q the expected read data
# L load entry (flag marks last), D wait for load done, K expected char, F finish level, S drain core
L 80000000 1111000011110000 0
L 80000008 2222000022220000 0
L 80000010 3333000033330000 0
L 80000018 4444000044440000 0
L 80000020 5555000055550000 0
L 80000028 6666000066660000 1
W 80000400 0a0a0a0a0a0a0a0a 0
W 80000408 0b0b0b0b0b0b0b0b 0
R 80000400 0a0a0a0a0a0a0a0a 0
R 80000408 0b0b0b0b0b0b0b0b 0
D 00000000 0000000000000000 1
R 80000000 1111000011110000 0
R 80000008 2222000022220000 0
R 80000010 3333000033330000 0
R 80000018 4444000044440000 0
R 80000020 5555000055550000 0
R 80000028 6666000066660000 0
K 00000000 0000000000000048 0
P 00100000 0000000000000048 0
K 00000000 0000000000000069 0
P 00100000 0000000000000069 0
Q 00100008 0000000000000002 0
P 00100010 0000000000000001 0
F 00000000 0000000000000000 1
R 80000408 0b0b0b0b0b0b0b0b 0
S 00000000 0000000000000000 0
F 00000000 0000000000000000 1

/* sim.f */
hw/harness_pkg.sv
hw/mem_bus_if.sv
hw/nbf_loader.sv
hw/mem_arbiter.sv
hw/mem_model.sv
hw/host_device.sv
hw/harness_top.sv
testbench/harness_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the harness testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

if ! verilator --binary --timing --assert -sv --top-module harness_tb \
      -f sim.f -o harness_sim; then
   echo "Verilator build failed"
   exit 1
fi

if ! ./obj_dir/harness_sim > sim.log 2>&1; then
   cat sim.log
   echo "Simulation exited with a failing status"
   exit 1
fi
cat sim.log

if grep -qx "No errors" sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1
